// File: rtl/fpu_pkg.sv
`default_nettype none

package fpu_pkg;

	// ####################
	// Scalar types
	// ####################

	typedef logic [31:0] fp32_t;   // Sign, exponent, fraction.
	typedef logic [31:0] word_t;   // Integer operand or result.
	typedef logic [7:0]  fp_exp_t; // Biased exponent.

	// ####################
	// Operation codes
	// ####################

	// Codes 0 to 7 belonged to the arithmetic cores and now decode as illegal.
	typedef enum logic [4:0] {
		MOV    = 5'd12,
		CMP_EQ = 5'd13,
		CMP_LT = 5'd14,
		CMP_LE = 5'd15,
		MIN    = 5'd19,
		MAX    = 5'd20,
		SGNJ   = 5'd16,
		SGNJN  = 5'd17,
		SGNJX  = 5'd18,
		F2I    = 5'd8,
		F2UI   = 5'd9,
		I2F    = 5'd10,
		UI2F   = 5'd11
	} fpu_op_e;

	// ####################
	// Request and response
	// ####################

	typedef struct packed {
		fpu_op_e op;
		fp32_t   op1;
		fp32_t   op2;
	} fpu_req_t;

	typedef struct packed {
		word_t result;
		logic  illegal;
	} fpu_rsp_t;

	// Quiet NaN returned when min or max has no number to pick.
	localparam fp32_t FP_CANON_NAN = 32'h7FC0_0000;

endpackage

`default_nettype wire

// File: rtl/fpu_compare.sv
`default_nettype none

module fpu_compare import fpu_pkg::*; (
	input  wire   i_clock,
	input  wire   i_arst_n,
	input  wire   i_start,
	input  wire   fp32_t i_op1,
	input  wire   fp32_t i_op2,
	output logic  o_done,
	output logic  o_less,
	output logic  o_equal,
	output fp32_t o_min,
	output fp32_t o_max
);

	logic nan1;
	logic nan2;
	logic any_nan;
	logic both_zero;
	logic lt_raw;

	// Strict order where -0 sits below +0.
	always_comb begin
		nan1      = (i_op1[30:23] == 8'hFF) && (i_op1[22:0] != 23'd0);
		nan2      = (i_op2[30:23] == 8'hFF) && (i_op2[22:0] != 23'd0);
		any_nan   = nan1 | nan2;
		both_zero = (i_op1[30:0] == 31'd0) && (i_op2[30:0] == 31'd0);

		if (i_op1[31] != i_op2[31])
			lt_raw = i_op1[31];                    // Negative one is smaller.
		else if (i_op1[31])
			lt_raw = i_op1[30:0] > i_op2[30:0];    // Both negative.
		else
			lt_raw = i_op1[30:0] < i_op2[30:0];
	end

	always_ff @(posedge i_clock or negedge i_arst_n) begin
		if (!i_arst_n)
			o_done <= 1'b0;
		else
			o_done <= i_start;
	end

	always_ff @(posedge i_clock) begin
		if (i_start) begin
			o_less  <= lt_raw && !both_zero && !any_nan;
			o_equal <= !any_nan && ((i_op1 == i_op2) || both_zero);

			if (nan1 && nan2) begin
				o_min <= FP_CANON_NAN;
				o_max <= FP_CANON_NAN;
			end else if (nan1) begin
				o_min <= i_op2;
				o_max <= i_op2;
			end else if (nan2) begin
				o_min <= i_op1;
				o_max <= i_op1;
			end else begin
				o_min <= lt_raw ? i_op1 : i_op2;
				o_max <= lt_raw ? i_op2 : i_op1;
			end
		end
	end

endmodule

`default_nettype wire

// File: rtl/fpu_convert.sv
`default_nettype none

module fpu_convert import fpu_pkg::*; #(
	parameter int P_NORM_STEP = 1
) (
	input  wire   i_clock,
	input  wire   i_arst_n,
	input  wire   i_start,
	input  wire   i_to_int,
	input  wire   i_signed,
	input  wire   word_t i_operand,
	output logic  o_done,
	output word_t o_result
);

	typedef enum logic {
		CV_IDLE,
		CV_NORM
	} cv_state_e;

	cv_state_e state;

	// ####################
	// Float to integer
	// ####################

	logic        f_sign;
	fp_exp_t     f_exp;
	logic [23:0] f_mant;
	logic        f_nan;
	logic [7:0]  f_shift;
	logic [54:0] f_shifted;
	word_t       f_mag;
	word_t       f_int;

	always_comb begin
		f_sign    = i_operand[31];
		f_exp     = i_operand[30:23];
		f_mant    = {1'b1, i_operand[22:0]};
		f_nan     = (f_exp == 8'hFF) && (i_operand[22:0] != 23'd0);
		f_shift   = f_exp - 8'd127;
		f_shifted = {31'd0, f_mant} << f_shift[4:0];
		f_mag     = f_shifted[54:23];   // Fraction bits fall off here.

		if (f_nan)
			f_int = i_signed ? 32'h7FFF_FFFF : 32'hFFFF_FFFF;
		else if (f_exp < 8'd127)
			f_int = '0;   // Magnitude below one.
		else if (i_signed) begin
			if (f_shift >= 8'd31)
				f_int = f_sign ? 32'h8000_0000 : 32'h7FFF_FFFF;
			else
				f_int = f_sign ? -f_mag : f_mag;
		end else begin
			if (f_sign)
				f_int = '0;
			else if (f_shift >= 8'd32)
				f_int = 32'hFFFF_FFFF;
			else
				f_int = f_mag;
		end
	end

	// ####################
	// Integer to float
	// ####################

	logic    n_sign;
	fp_exp_t n_exp;
	word_t   n_mag;
	logic    n_found;
	logic [7:0] n_lead;
	word_t   n_top;
	word_t   n_float;

	// Leading one inside the top step window finishes the normalize.
	always_comb begin
		n_lead  = '0;
		n_found = 1'b0;
		for (int i = 0; i < P_NORM_STEP; i++) begin
			if (!n_found && n_mag[31 - i]) begin
				n_lead  = 8'(i);
				n_found = 1'b1;
			end
		end
		n_top   = n_mag << n_lead;
		n_float = {n_sign, fp_exp_t'(n_exp - n_lead), n_top[30:8]};
	end

	always_ff @(posedge i_clock or negedge i_arst_n) begin
		if (!i_arst_n) begin
			state  <= CV_IDLE;
			o_done <= 1'b0;
		end else begin
			o_done <= 1'b0;
			case (state)
				CV_IDLE: begin
					if (i_start) begin
						if (i_to_int)
							o_done <= 1'b1;
						else
							state <= CV_NORM;
					end
				end
				CV_NORM: begin
					if (n_mag == '0 || n_found) begin
						o_done <= 1'b1;
						state  <= CV_IDLE;
					end
				end
				default: state <= CV_IDLE;
			endcase
		end
	end

	always_ff @(posedge i_clock) begin
		if (state == CV_IDLE && i_start) begin
			if (i_to_int)
				o_result <= f_int;
			else begin
				n_sign <= i_signed & i_operand[31];
				n_mag  <= (i_signed && i_operand[31]) ? -i_operand : i_operand;
				n_exp  <= 8'd158;   // Bias plus 31.
			end
		end else if (state == CV_NORM) begin
			if (n_mag == '0)
				o_result <= '0;
			else if (n_found)
				o_result <= n_float;
			else begin
				n_mag <= n_mag << P_NORM_STEP;
				n_exp <= n_exp - 8'(P_NORM_STEP);
			end
		end
	end

endmodule

`default_nettype wire

// File: rtl/fpu_dispatch.sv
`default_nettype none

module fpu_dispatch import fpu_pkg::*; #(
	parameter int P_NORM_STEP = 1
) (
	input  wire      i_clock,
	input  wire      i_arst_n,
	input  wire      i_start,
	input  wire      fpu_req_t i_cmd,
	output logic     o_done,
	output fpu_rsp_t o_rsp
);

	fpu_op_e op_q;
	fpu_op_e op_sel;
	logic    is_cmp;
	logic    is_cvt;

	logic  cmp_done;
	logic  cmp_less;
	logic  cmp_equal;
	fp32_t cmp_min;
	fp32_t cmp_max;

	logic  cv_done;
	word_t cv_result;

	always_ff @(posedge i_clock or negedge i_arst_n) begin
		if (!i_arst_n)
			op_q <= MOV;
		else if (i_start)
			op_q <= i_cmd.op;
	end

	assign op_sel = i_start ? i_cmd.op : op_q;   // Start cycle sees the new code.

	always_comb begin
		is_cmp = 1'b0;
		is_cvt = 1'b0;
		case (op_sel)
			CMP_EQ, CMP_LT, CMP_LE, MIN, MAX: is_cmp = 1'b1;
			F2I, F2UI, I2F, UI2F:             is_cvt = 1'b1;
			default: ;
		endcase
	end

	fpu_compare u_compare (
		.i_clock  (i_clock),
		.i_arst_n (i_arst_n),
		.i_start  (i_start & is_cmp),
		.i_op1    (i_cmd.op1),
		.i_op2    (i_cmd.op2),
		.o_done   (cmp_done),
		.o_less   (cmp_less),
		.o_equal  (cmp_equal),
		.o_min    (cmp_min),
		.o_max    (cmp_max)
	);

	fpu_convert #(
		.P_NORM_STEP (P_NORM_STEP)
	) u_convert (
		.i_clock   (i_clock),
		.i_arst_n  (i_arst_n),
		.i_start   (i_start & is_cvt),
		.i_to_int  (op_sel == F2I || op_sel == F2UI),
		.i_signed  (op_sel == F2I || op_sel == I2F),
		.i_operand (i_cmd.op1),
		.o_done    (cv_done),
		.o_result  (cv_result)
	);

	// Inline ops and illegal codes complete with start.
	assign o_done = i_start ? !(is_cmp | is_cvt)
	                        : (is_cmp & cmp_done) | (is_cvt & cv_done);

	always_comb begin
		o_rsp = '0;
		case (op_sel)
			MOV:    o_rsp.result = i_cmd.op1;
			SGNJ:   o_rsp.result = {i_cmd.op2[31], i_cmd.op1[30:0]};
			SGNJN:  o_rsp.result = {~i_cmd.op2[31], i_cmd.op1[30:0]};
			SGNJX:  o_rsp.result = {i_cmd.op1[31] ^ i_cmd.op2[31], i_cmd.op1[30:0]};
			CMP_EQ: o_rsp.result = {31'd0, cmp_equal};
			CMP_LT: o_rsp.result = {31'd0, cmp_less};
			CMP_LE: o_rsp.result = {31'd0, cmp_equal | cmp_less};
			MIN:    o_rsp.result = cmp_min;
			MAX:    o_rsp.result = cmp_max;
			F2I, F2UI, I2F, UI2F: o_rsp.result = cv_result;
			default: o_rsp.illegal = 1'b1;
		endcase
	end

endmodule

`default_nettype wire

// File: rtl/fpu_handshake_port.sv
`default_nettype none

module fpu_handshake_port import fpu_pkg::*; (
	input  wire      i_clock,
	input  wire      i_arst_n,
	input  wire      i_req,
	input  wire      fpu_req_t i_req_data,
	output logic     o_ack,
	output fpu_rsp_t o_rsp,
	output logic     o_start,
	output fpu_req_t o_cmd,
	input  wire      i_done,
	input  wire      fpu_rsp_t i_rsp
);

	typedef enum logic [1:0] {
		IDLE,
		BUSY,
		ACK
	} hs_state_e;

	hs_state_e state;

	always_ff @(posedge i_clock or negedge i_arst_n) begin
		if (!i_arst_n) begin
			state   <= IDLE;
			o_start <= 1'b0;
		end else begin
			o_start <= 1'b0;
			case (state)
				IDLE: begin
					if (i_req) begin
						state   <= BUSY;
						o_start <= 1'b1;
					end
				end
				BUSY:    if (i_done) state <= ACK;
				ACK:     if (!i_req) state <= IDLE;   // Requester let go.
				default: state <= IDLE;
			endcase
		end
	end

	assign o_ack = (state == ACK);

	// Request and response payload.
	always_ff @(posedge i_clock) begin
		if (state == IDLE && i_req)
			o_cmd <= i_req_data;
		if (state == BUSY && i_done)
			o_rsp <= i_rsp;
	end

endmodule

`default_nettype wire

// File: rtl/fpu_top.sv
`default_nettype none

module fpu_top import fpu_pkg::*; #(
	parameter int P_NORM_STEP = 1
) (
	input  wire      i_clock,
	input  wire      i_arst_n,
	input  wire      i_req,
	input  wire      fpu_req_t i_req_data,
	output logic     o_ack,
	output fpu_rsp_t o_rsp
);

	logic     start;
	fpu_req_t cmd;
	logic     done;
	fpu_rsp_t rsp;

	fpu_handshake_port u_port (
		.i_clock    (i_clock),
		.i_arst_n   (i_arst_n),
		.i_req      (i_req),
		.i_req_data (i_req_data),
		.o_ack      (o_ack),
		.o_rsp      (o_rsp),
		.o_start    (start),
		.o_cmd      (cmd),
		.i_done     (done),
		.i_rsp      (rsp)
	);

	fpu_dispatch #(
		.P_NORM_STEP (P_NORM_STEP)
	) u_dispatch (
		.i_clock  (i_clock),
		.i_arst_n (i_arst_n),
		.i_start  (start),
		.i_cmd    (cmd),
		.o_done   (done),
		.o_rsp    (rsp)
	);

endmodule

`default_nettype wire

// File: verification/fpu_properties.sv
`default_nettype none

module fpu_properties import fpu_pkg::*; (
	input wire           i_clock,
	input wire           i_arst_n,
	input wire           i_req,
	input wire fpu_req_t i_req_data,
	input wire           i_ack,
	input wire fpu_rsp_t i_rsp
);

	int assert_failures = 0;   // Read by the testbench at the end.

	// ####################
	// Four-phase rules
	// ####################

	// Idle with no request stays idle.
	ack_needs_req: assert property (@(posedge i_clock) disable iff (!i_arst_n)
		!i_req && !i_ack |=> !i_ack)
		else begin
			$error("o_ack rose while i_req was low");
			assert_failures++;
		end

	rsp_stable: assert property (@(posedge i_clock) disable iff (!i_arst_n)
		i_ack && $past(i_ack) |-> $stable(i_rsp))
		else begin
			$error("o_rsp changed while o_ack was high");
			assert_failures++;
		end

	ack_held: assert property (@(posedge i_clock) disable iff (!i_arst_n)
		i_ack && i_req |=> i_ack)   // Released only by the requester.
		else begin
			$error("o_ack fell before i_req was released");
			assert_failures++;
		end

	data_stable: assert property (@(posedge i_clock) disable iff (!i_arst_n)
		i_req && $past(i_req) |-> $stable(i_req_data))
		else begin
			$error("i_req_data changed while i_req was high");
			assert_failures++;
		end

endmodule

bind fpu_top fpu_properties u_properties (
	.i_clock    (i_clock),
	.i_arst_n   (i_arst_n),
	.i_req      (i_req),
	.i_req_data (i_req_data),
	.i_ack      (o_ack),
	.i_rsp      (o_rsp)
);

`default_nettype wire

// File: verification/fpu_tb.sv
`default_nettype none

module fpu_tb import fpu_pkg::*; ();

	localparam int CLK_PERIOD   = 10;
	localparam int DRIVE_DELAY  = 1;
	localparam int RESET_CYCLES = 4;
	localparam int WORST_CYCLES = 48;   // Longest normalize plus hold.

	typedef struct packed {
		logic [4:0] op;
		fp32_t      op1;
		fp32_t      op2;
		word_t      result;
		logic       illegal;
		logic [3:0] hold;
	} test_row_t;

	logic     clk;
	logic     arst_n;
	logic     req;
	fpu_req_t req_data;
	logic     ack;
	fpu_rsp_t rsp;

	test_row_t rows[$];
	string     names[$];
	logic      table_built = 1'b0;
	int        seed        = 27228;
	int        error_count = 0;
	int        pass_count  = 0;
	int        fail_count  = 0;

	fpu_top #(
		.P_NORM_STEP (1)
	) UUT (
		.i_clock    (clk),
		.i_arst_n   (arst_n),
		.i_req      (req),
		.i_req_data (req_data),
		.o_ack      (ack),
		.o_rsp      (rsp)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// ####################
	// Helpers
	// ####################

	task automatic compare_value(input string sig, input logic [31:0] got,
			input logic [31:0] expected);
		if (got !== expected) begin
			$display("[ERROR] %0t %s got %08h expected %08h", $time, sig, got, expected);
			error_count++;
		end
	endtask

	// Value mismatches plus handshake property failures.
	function automatic int error_total();
		return error_count + UUT.u_properties.assert_failures;
	endfunction

	task automatic add_row(input string name, input logic [4:0] op, input fp32_t a,
			input fp32_t b, input word_t result, input logic illegal, input int hold = 0);
		test_row_t row;
		row.op      = op;
		row.op1     = a;
		row.op2     = b;
		row.result  = result;
		row.illegal = illegal;
		row.hold    = 4'(hold);
		rows.push_back(row);
		names.push_back(name);
	endtask

	task automatic build_table();
		add_row("mov pi", MOV, 32'h4049_0FDB, 32'h0000_0000, 32'h4049_0FDB, 1'b0);
		add_row("sgnj neg", SGNJ, 32'h3F80_0000, 32'hC000_0000, 32'hBF80_0000, 1'b0);
		add_row("sgnjn neg", SGNJN, 32'h3F80_0000, 32'hC000_0000, 32'h3F80_0000, 1'b0);
		add_row("sgnjx both neg", SGNJX, 32'hBF80_0000, 32'hC000_0000, 32'h3F80_0000, 1'b0);
		add_row("sgnj nan", SGNJ, 32'h7FC0_0000, 32'h8000_0000, 32'hFFC0_0000, 1'b0);
		// Compares.
		add_row("eq same", CMP_EQ, 32'h3F80_0000, 32'h3F80_0000, 32'd1, 1'b0);
		add_row("eq signed zero", CMP_EQ, 32'h0000_0000, 32'h8000_0000, 32'd1, 1'b0);
		add_row("eq nan", CMP_EQ, 32'h7FC0_0000, 32'h7FC0_0000, 32'd0, 1'b0);
		add_row("lt mixed sign", CMP_LT, 32'hBF80_0000, 32'h3F80_0000, 32'd1, 1'b0);
		add_row("lt both neg", CMP_LT, 32'hC020_0000, 32'hBF80_0000, 32'd1, 1'b0);
		add_row("lt signed zero", CMP_LT, 32'h8000_0000, 32'h0000_0000, 32'd0, 1'b0);
		add_row("lt nan", CMP_LT, 32'h3F80_0000, 32'h7FC0_0000, 32'd0, 1'b0);
		add_row("lt inf", CMP_LT, 32'hFF80_0000, 32'h7F80_0000, 32'd1, 1'b0);
		add_row("le equal", CMP_LE, 32'h4000_0000, 32'h4000_0000, 32'd1, 1'b0);
		add_row("le greater", CMP_LE, 32'h4020_0000, 32'h4000_0000, 32'd0, 1'b0);
		add_row("le snan", CMP_LE, 32'h7F80_0001, 32'h3F80_0000, 32'd0, 1'b0);
		// Min and max.
		add_row("min", MIN, 32'h3F80_0000, 32'hBF80_0000, 32'hBF80_0000, 1'b0);
		add_row("max", MAX, 32'h3F80_0000, 32'hBF80_0000, 32'h3F80_0000, 1'b0);
		add_row("min signed zero", MIN, 32'h0000_0000, 32'h8000_0000, 32'h8000_0000, 1'b0);
		add_row("max signed zero", MAX, 32'h8000_0000, 32'h0000_0000, 32'h0000_0000, 1'b0);
		add_row("min one nan", MIN, 32'h7FC0_0000, 32'h4000_0000, 32'h4000_0000, 1'b0);
		add_row("max one nan", MAX, 32'hC020_0000, 32'hFFC0_0001, 32'hC020_0000, 1'b0);
		add_row("min both nan", MIN, 32'h7FC0_0000, 32'h7F80_0001, FP_CANON_NAN, 1'b0);
		add_row("max both nan", MAX, 32'h7F80_0001, 32'hFFC0_0001, FP_CANON_NAN, 1'b0);
		// Float to integer.
		add_row("f2i 3.75", F2I, 32'h4070_0000, 32'h0, 32'h0000_0003, 1'b0);
		add_row("f2i -3.75", F2I, 32'hC070_0000, 32'h0, 32'hFFFF_FFFD, 1'b0);
		add_row("f2i 0.5", F2I, 32'h3F00_0000, 32'h0, 32'h0000_0000, 1'b0);
		add_row("f2i 2^31", F2I, 32'h4F00_0000, 32'h0, 32'h7FFF_FFFF, 1'b0);
		add_row("f2i -2^31", F2I, 32'hCF00_0000, 32'h0, 32'h8000_0000, 1'b0);
		add_row("f2i -2^33", F2I, 32'hD000_0000, 32'h0, 32'h8000_0000, 1'b0);
		add_row("f2i large", F2I, 32'h4EFF_FFFF, 32'h0, 32'h7FFF_FF80, 1'b0);
		add_row("f2i nan", F2I, 32'h7FC0_0000, 32'h0, 32'h7FFF_FFFF, 1'b0);
		add_row("f2i -inf", F2I, 32'hFF80_0000, 32'h0, 32'h8000_0000, 1'b0);
		add_row("f2ui 3.75", F2UI, 32'h4070_0000, 32'h0, 32'h0000_0003, 1'b0);
		add_row("f2ui negative", F2UI, 32'hC070_0000, 32'h0, 32'h0000_0000, 1'b0);
		add_row("f2ui 3e9", F2UI, 32'h4F32_D05E, 32'h0, 32'hB2D0_5E00, 1'b0);
		add_row("f2ui 2^32", F2UI, 32'h4F80_0000, 32'h0, 32'hFFFF_FFFF, 1'b0);
		add_row("f2ui nan", F2UI, 32'h7FC0_0000, 32'h0, 32'hFFFF_FFFF, 1'b0);
		add_row("f2ui inf", F2UI, 32'h7F80_0000, 32'h0, 32'hFFFF_FFFF, 1'b0);
		// Integer to float, low bits truncated.
		add_row("i2f 0", I2F, 32'h0000_0000, 32'h0, 32'h0000_0000, 1'b0);
		add_row("i2f 1", I2F, 32'h0000_0001, 32'h0, 32'h3F80_0000, 1'b0);
		add_row("i2f -1", I2F, 32'hFFFF_FFFF, 32'h0, 32'hBF80_0000, 1'b0);
		add_row("i2f -3", I2F, 32'hFFFF_FFFD, 32'h0, 32'hC040_0000, 1'b0, 3);
		add_row("i2f min int", I2F, 32'h8000_0000, 32'h0, 32'hCF00_0000, 1'b0);
		add_row("i2f 25 bits", I2F, 32'h01FF_FFFF, 32'h0, 32'h4BFF_FFFF, 1'b0);
		add_row("i2f max int", I2F, 32'h7FFF_FFFF, 32'h0, 32'h4EFF_FFFF, 1'b0);
		add_row("i2f 4096", I2F, 32'h0000_1000, 32'h0, 32'h4580_0000, 1'b0);
		add_row("ui2f all ones", UI2F, 32'hFFFF_FFFF, 32'h0, 32'h4F7F_FFFF, 1'b0);
		add_row("ui2f 2^31", UI2F, 32'h8000_0000, 32'h0, 32'h4F00_0000, 1'b0);
		add_row("ui2f 0", UI2F, 32'h0000_0000, 32'h0, 32'h0000_0000, 1'b0);
		add_row("ui2f 3", UI2F, 32'h0000_0003, 32'h0, 32'h4040_0000, 1'b0);
		// Arithmetic codes are out of the unit.
		add_row("illegal add", 5'd0, 32'h3F80_0000, 32'h3F80_0000, 32'd0, 1'b1, 5);
		add_row("illegal top code", 5'd31, 32'h4000_0000, 32'h4000_0000, 32'd0, 1'b1);
	endtask

	task automatic add_random_rows();
		word_t      a;
		word_t      b;
		word_t      r;
		logic       s;
		logic [4:0] op;
		for (int k = 0; k < 20; k++) begin
			a = $random(seed);
			b = $random(seed);
			r = $random(seed);
			case (r[1:0])
				2'd0: begin
					op = SGNJ;
					s  = b[31];
				end
				2'd1: begin
					op = SGNJN;
					s  = ~b[31];
				end
				default: begin
					op = SGNJX;
					s  = a[31] ^ b[31];
				end
			endcase
			add_row($sformatf("random sgnj %0d", k), op, a, b, {s, a[30:0]}, 1'b0);
		end
	endtask

	// ####################
	// One request
	// ####################

	task automatic run_row(input int idx);
		test_row_t row;
		fpu_rsp_t  held;
		int        cycles;
		int        errors_before;
		row           = rows[idx];
		errors_before = error_total();
		req_data.op   = fpu_op_e'(row.op);
		req_data.op1  = row.op1;
		req_data.op2  = row.op2;
		req           = 1'b1;
		cycles        = 0;
		do begin
			@(posedge clk);
			#DRIVE_DELAY;
			cycles++;
		end while (!ack && cycles < WORST_CYCLES);
		if (!ack) begin
			$display("Test %0d (%s): no acknowledge within %0d cycles", idx, names[idx],
				WORST_CYCLES);
			error_count++;
		end else begin
			compare_value("o_rsp.result", rsp.result, row.result);
			compare_value("o_rsp.illegal", {31'd0, rsp.illegal}, {31'd0, row.illegal});
			held = rsp;
			repeat (row.hold) begin   // Requester stalls with i_req high.
				@(posedge clk);
				#DRIVE_DELAY;
				compare_value("o_ack", {31'd0, ack}, 32'd1);
				compare_value("o_rsp.result", rsp.result, held.result);
				compare_value("o_rsp.illegal", {31'd0, rsp.illegal}, {31'd0, held.illegal});
			end
		end
		req    = 1'b0;
		cycles = 0;
		do begin
			@(posedge clk);
			#DRIVE_DELAY;
			cycles++;
		end while (ack && cycles < 4);
		if (ack) begin
			$display("Test %0d (%s): o_ack stayed high after i_req was released", idx,
				names[idx]);
			error_count++;
		end
		if (error_total() == errors_before) begin
			pass_count++;
			$display("Test %0d %s: pass", idx, names[idx]);
		end else begin
			fail_count++;
			$display("Test %0d %s: FAIL", idx, names[idx]);
		end
	endtask

	// ####################
	// Main sequence
	// ####################

	initial begin
		req      = 1'b0;
		req_data = '0;
		arst_n   = 1'b0;
		build_table();
		add_random_rows();
		table_built = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		#DRIVE_DELAY;
		arst_n = 1'b1;
		for (int i = 0; i < rows.size(); i++)
			run_row(i);
		$display("%0d tests, %0d passed, %0d failed, %0d errors", rows.size(), pass_count,
			fail_count, error_total());
		if (error_total() == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

	initial begin
		longint limit;
		wait (table_built);
		limit = longint'(RESET_CYCLES + rows.size() * WORST_CYCLES) * CLK_PERIOD;
		#(limit);
		$display("Watchdog expired after %0d time units, the run did not finish", limit);
		$display("Errors found");
		$finish;
	end

endmodule

`default_nettype wire

// File: files.f
rtl/fpu_pkg.sv
rtl/fpu_compare.sv
rtl/fpu_convert.sv
rtl/fpu_dispatch.sv
rtl/fpu_handshake_port.sv
rtl/fpu_top.sv
verification/fpu_properties.sv
verification/fpu_tb.sv

// File: Makefile
# Verilator simulation of the FPU testbench.

VERILATOR ?= verilator
TOP       ?= fpu_tb
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_TEXT ?= No errors

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
